// File: flist.f
rtl/decode_pkg.sv
rtl/field_extract.sv
rtl/ucode_rom.sv
rtl/decode_stage2.sv
rtl/uop_credit_queue.sv
rtl/decode2_top.sv
bench/tb_decode2.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run tb_decode2 with Verilator, exit status follows the testbench result
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_decode2 \
      -f flist.f -Mdir obj_dir -o sim_decode2; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_decode2)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi

// File: bench/tb_decode2.sv
`timescale 1ns/1ps

module tb_decode2
   import decode_pkg::*;
();

   localparam int DEPTH          = 4;
   localparam int AG_CREDITS     = 2;
   // the whole run needs a few hundred cycles at most
   localparam int timeout_cycles = 2000;

   logic clk = 1'b0;
   logic rst_n;
   logic in_valid;
   logic [ir_w-1:0] ir;
   logic [15:0] opcode;
   logic operand_override, modrm_present, sib_present, disp_present, disp_size, imm_present;
   logic [7:0] modrm, sib;
   logic [2:0] disp_sel;
   logic [1:0] imm_size;
   logic [3:0] imm_sel;
   logic out_credit = 1'b0;
   logic in_credit, out_valid;
   logic [1:0] data_size, sib_scale;
   logic sr1_needed, seg1_needed, mm1_needed, mem_rd, mem_wr, ld_gpr1, ld_mm;
   logic [2:0] aluk, sr1, sr2, seg1, seg2, sib_index;
   logic sib_en, disp_en, cmpxchg, illegal;
   logic [31:0] imm32, disp32;

   // expected micro-ops, written by the stimulus side, read by the monitor
   uop_t  exp_arr [256];
   string exp_name [256];
   int exp_wr = 0;
   int exp_rd = 0;
   // sender and address-generation bookkeeping
   int sent = 0;
   int credits_seen = 0;
   int beats = 0;
   int credits_returned = 0;
   int credit_limit = 1 << 30;
   int cycles = 0;

   decode2_top #(.DEPTH(DEPTH), .AG_CREDITS(AG_CREDITS)) i_dut (.*);

   always #5 clk = ~clk;

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
      if (exp !== act) begin
         $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
         abort_run();
      end
   endtask

   // byte k of the window, zero past the 16-byte end
   function automatic logic [7:0] window_byte(logic [ir_w-1:0] win, int k);
      if (k < 16) begin
         return win[8*k +: 8];
      end
      return 8'h00;
   endfunction

   // expected micro-op from the decode rules
   task automatic model_push(string tname, logic [15:0] op, logic ovr, logic [7:0] mrm,
                             logic sib_p, logic [7:0] sb, logic dp, logic dsz,
                             logic [2:0] dsel, logic ip, logic [1:0] isz, logic [3:0] isel,
                             logic [ir_w-1:0] win);
      uop_t u;
      logic reg_form;
      logic [31:0] draw;
      logic [31:0] iraw;
      reg_form = (mrm[7:6] == 2'b11);
      u = '0;
      u.seg1_needed = !reg_form;
      if (op inside {16'h0001, 16'h0003, 16'h0081, 16'h0089, 16'h0FB1}) begin
         // gpr r/m forms, dword by default
         u.mem_rd     = (op == 16'h0089) ? 1'b0 : !reg_form;
         u.mem_wr     = (op == 16'h0003) ? 1'b0 : !reg_form;
         u.ld_gpr1    = reg_form || (op == 16'h0003);
         u.sr1_needed = 1'b1;
         u.data_size  = 2'b10;
         case (op)
            16'h0081: u.aluk = mrm[5:3];
            16'h0089: u.aluk = 3'b111;
            16'h0FB1: u.aluk = 3'b001;
            default:  u.aluk = 3'b000;
         endcase
      end else if (op == 16'h0F6F) begin
         u.mm1_needed = reg_form;
         u.ld_mm      = 1'b1;
         u.mem_rd     = !reg_form;
         u.sr1_needed = !reg_form;
         u.data_size  = 2'b11;
      end else if (op == 16'h0F7F) begin
         // register form writes the rm mmx register
         u.ld_mm      = reg_form;
         u.mem_wr     = !reg_form;
         u.sr1_needed = !reg_form;
         u.data_size  = 2'b11;
      end else begin
         u.illegal = 1'b1;
      end
      if (ovr && op != 16'h0F6F && op != 16'h0F7F) begin
         u.data_size = 2'b01;
      end
      u.sr1       = sib_p ? sb[2:0] : mrm[2:0];
      u.sr2       = mrm[5:3];
      u.seg1      = 3'b011;
      u.seg2      = 3'b010;
      u.sib_index = sb[5:3];
      u.sib_scale = sb[7:6];
      u.sib_en    = sib_p;
      u.disp_en   = dp;
      u.cmpxchg   = (op == 16'h0FB0) || (op == 16'h0FB1);
      // little endian fields from the window
      for (int k = 0; k < 4; k++) begin
         draw[8*k +: 8] = window_byte(win, int'(dsel) + k);
         iraw[8*k +: 8] = window_byte(win, int'(isel) + k);
      end
      if (dp) begin
         u.disp32 = dsz ? draw : {{24{draw[7]}}, draw[7:0]};
      end
      if (ip) begin
         case (isz)
            2'b00:   u.imm32 = {{24{iraw[7]}}, iraw[7:0]};
            2'b01:   u.imm32 = {{16{iraw[15]}}, iraw[15:0]};
            default: u.imm32 = iraw;
         endcase
      end
      exp_arr[exp_wr]  = u;
      exp_name[exp_wr] = tname;
      exp_wr++;
   endtask

   // one instruction from decode stage 1, waits for an upstream credit
   task automatic send(string tname, logic [15:0] op, logic ovr, logic [7:0] mrm,
                       logic sib_p, logic [7:0] sb, logic dp, logic dsz, logic [2:0] dsel,
                       logic ip, logic [1:0] isz, logic [3:0] isel);
      logic [ir_w-1:0] win;
      win = {$urandom, $urandom, $urandom, $urandom};
      while (DEPTH - sent + credits_seen <= 0) begin
         @(posedge clk);
         #1;
      end
      model_push(tname, op, ovr, mrm, sib_p, sb, dp, dsz, dsel, ip, isz, isel, win);
      ir               = win;
      opcode           = op;
      operand_override = ovr;
      modrm_present    = 1'b1;
      modrm            = mrm;
      sib_present      = sib_p;
      sib              = sb;
      disp_present     = dp;
      disp_size        = dsz;
      disp_sel         = dsel;
      imm_present      = ip;
      imm_size         = isz;
      imm_sel          = isel;
      in_valid         = 1'b1;
      sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic compare_uop(string tname, uop_t e);
      check_eq({tname, " ctrl"},
         64'({e.data_size, e.sr1_needed, e.seg1_needed, e.mm1_needed, e.mem_rd, e.mem_wr,
              e.aluk, e.ld_gpr1, e.ld_mm, e.cmpxchg, e.illegal}),
         64'({data_size, sr1_needed, seg1_needed, mm1_needed, mem_rd, mem_wr,
              aluk, ld_gpr1, ld_mm, cmpxchg, illegal}));
      check_eq({tname, " regs"},
         64'({e.sr1, e.sr2, e.seg1, e.seg2, e.sib_index, e.sib_scale, e.sib_en, e.disp_en}),
         64'({sr1, sr2, seg1, seg2, sib_index, sib_scale, sib_en, disp_en}));
      check_eq({tname, " imm32"}, 64'(e.imm32), 64'(imm32));
      check_eq({tname, " disp32"}, 64'(e.disp32), 64'(disp32));
   endtask

   // sample mid-cycle, outputs settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (in_credit) begin
            credits_seen++;
         end
         if (out_valid && exp_rd == exp_wr) begin
            $display("ERROR: out_valid asserted with no micro-op outstanding");
            abort_run();
         end else if (out_valid) begin
            compare_uop(exp_name[exp_rd], exp_arr[exp_rd]);
            exp_rd++;
            beats++;
         end
      end
   end

   // address generation returns one credit per beat, up to credit_limit
   always @(posedge clk) begin
      // decided on the edge, driven just after it
      if (rst_n && beats > credits_returned && credits_returned < credit_limit) begin
         credits_returned++;
         #1;
         out_credit = 1'b1;
      end else begin
         #1;
         out_credit = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("ERROR: timeout after %0d cycles, DUT stopped delivering micro-ops", cycles);
         abort_run();
      end
   end

   // all entries delivered and all credits home on both sides
   task automatic wait_idle();
      while (exp_rd != exp_wr || credits_returned != beats || credits_seen != sent) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic reset_and_latency();
      logic [2:0] r;
      logic [2:0] m;
      @(negedge clk);
      check_eq("reset out_valid", 64'(0), 64'(out_valid));
      check_eq("reset in_credit", 64'(0), 64'(in_credit));
      @(posedge clk);
      #1;
      r = 3'($urandom);
      m = 3'($urandom);
      send("reset_latency", op_add_rm_r, 1'b0, {2'b11, r, m}, 1'b0, 8'h00,
           1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      // one cycle after the write edge
      @(negedge clk);
      check_eq("reset_latency out_valid", 64'(1), 64'(out_valid));
      wait_idle();
   endtask

   task automatic memory_forms();
      logic [15:0] ops [3];
      logic [7:0] mrm;
      ops = '{op_add_rm_r, op_mov_rm_r, op_add_r_rm};
      for (int o = 0; o < 3; o++) begin
         for (int md = 0; md < 3; md++) begin
            for (int s = 0; s < 2; s++) begin
               // rm 100 escapes to a SIB byte
               mrm = {2'(md), 3'($urandom), (s != 0) ? 3'b100 : 3'($urandom)};
               send("mem_forms", ops[o], 1'b0, mrm, 1'(s), 8'($urandom),
                    md != 0, md == 2, 3'($urandom), 1'b0, 2'b00, 4'd0);
            end
         end
      end
      wait_idle();
   endtask

   task automatic group1_immediates();
      for (int r = 0; r < 8; r++) begin
         for (int sz = 0; sz < 3; sz++) begin
            send("grp1_imm", op_grp1_imm, 1'($urandom), {2'($urandom), 3'(r), 3'($urandom)},
                 1'b0, 8'h00, 1'b0, 1'b0, 3'd0, 1'b1, 2'(sz), 4'($urandom));
         end
      end
      wait_idle();
   endtask

   task automatic mmx_and_cmpxchg();
      logic [1:0] md;
      for (int m = 0; m < 2; m++) begin
         md = (m != 0) ? 2'b11 : 2'b00;
         send("mmx_0f7f", op_movq_rm_mm, 1'b0, {md, 6'($urandom)}, 1'b0, 8'h00,
              1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
         // 66h must not shrink a qword mmx move
         send("mmx_0f6f", op_movq_mm_rm, 1'(m), {md, 6'($urandom)}, 1'b0, 8'h00,
              1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      end
      send("cmpxchg_0fb0", 16'h0FB0, 1'b0, {2'b11, 6'($urandom)}, 1'b0, 8'h00,
           1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      send("cmpxchg_0fb1", op_cmpxchg, 1'b0, {2'b01, 6'($urandom)}, 1'b0, 8'h00,
           1'b1, 1'b0, 3'($urandom), 1'b0, 2'b00, 4'd0);
      send("illegal_hlt", 16'h00F4, 1'b0, {2'b11, 6'($urandom)}, 1'b0, 8'h00,
           1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      send("illegal_ud2", 16'h0F0B, 1'b0, {2'b00, 6'($urandom)}, 1'b0, 8'h00,
           1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      wait_idle();
   endtask

   task automatic credit_backpressure();
      int b0;
      int c0;
      wait_idle();
      // address generation holds every credit from here
      credit_limit = credits_returned;
      b0 = beats;
      c0 = credits_seen;
      for (int i = 0; i < DEPTH + AG_CREDITS; i++) begin
         send("backpressure", op_add_rm_r, 1'b0, {2'($urandom), 6'($urandom)}, 1'b0,
              8'h00, 1'b0, 1'b0, 3'd0, 1'b0, 2'b00, 4'd0);
      end
      repeat (8) begin
         @(posedge clk);
         #1;
      end
      check_eq("backpressure beats", 64'(AG_CREDITS), 64'(beats - b0));
      check_eq("backpressure in_credit", 64'(AG_CREDITS), 64'(credits_seen - c0));
      // one credit back releases exactly one entry
      for (int i = 0; i < DEPTH; i++) begin
         credit_limit++;
         while (beats - b0 != AG_CREDITS + i + 1) begin
            @(posedge clk);
            #1;
         end
         repeat (3) begin
            @(posedge clk);
            #1;
         end
         check_eq("drip beats", 64'(AG_CREDITS + i + 1), 64'(beats - b0));
         check_eq("drip in_credit", 64'(AG_CREDITS + i + 1), 64'(credits_seen - c0));
      end
      credit_limit = 1 << 30;
      wait_idle();
   endtask

   initial begin
      void'($urandom(98));
      rst_n            = 1'b0;
      in_valid         = 1'b0;
      ir               = '0;
      opcode           = '0;
      operand_override = 1'b0;
      modrm_present    = 1'b0;
      modrm            = '0;
      sib_present      = 1'b0;
      sib              = '0;
      disp_present     = 1'b0;
      disp_size        = 1'b0;
      disp_sel         = '0;
      imm_present      = 1'b0;
      imm_size         = '0;
      imm_sel          = '0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_and_latency();
      memory_forms();
      group1_immediates();
      mmx_and_cmpxchg();
      credit_backpressure();
      if (exp_rd == exp_wr && beats == sent) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("ERROR: %0d micro-ops sent but %0d delivered", sent, beats);
         abort_run();
      end
   end

endmodule

// File: rtl/decode2_top.sv
`timescale 1ns/1ps

module decode2_top
   import decode_pkg::*;
#(
   parameter int DEPTH      = 4,
   parameter int AG_CREDITS = 2
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  logic [ir_w-1:0] ir,
   input  logic [15:0]     opcode,
   input  logic            operand_override,
   input  logic            modrm_present,
   input  logic [7:0]      modrm,
   input  logic            sib_present,
   input  logic [7:0]      sib,
   input  logic            disp_present,
   input  logic            disp_size,
   input  logic [2:0]      disp_sel,
   input  logic            imm_present,
   input  logic [1:0]      imm_size,
   input  logic [3:0]      imm_sel,
   input  logic            out_credit,
   output logic            in_credit,
   output logic            out_valid,
   output logic [1:0]      data_size,
   output logic            sr1_needed,
   output logic            seg1_needed,
   output logic            mm1_needed,
   output logic            mem_rd,
   output logic            mem_wr,
   output logic [2:0]      aluk,
   output logic            ld_gpr1,
   output logic            ld_mm,
   output logic [2:0]      sr1,
   output logic [2:0]      sr2,
   output logic [2:0]      seg1,
   output logic [2:0]      seg2,
   output logic [2:0]      sib_index,
   output logic            sib_en,
   output logic            disp_en,
   output logic            cmpxchg,
   output logic            illegal,
   output logic [1:0]      sib_scale,
   output logic [31:0]     imm32,
   output logic [31:0]     disp32
);

   // decoded fields before the queue
   logic [1:0]  d_data_size;
   logic        d_sr1_needed, d_seg1_needed, d_mm1_needed;
   logic        d_mem_rd, d_mem_wr;
   logic [2:0]  d_aluk;
   logic        d_ld_gpr1, d_ld_mm;
   logic [2:0]  d_sr1, d_sr2, d_seg1, d_seg2, d_sib_index;
   logic        d_sib_en, d_disp_en, d_cmpxchg, d_illegal;
   logic [1:0]  d_sib_scale;
   logic [31:0] d_imm32, d_disp32;
   logic [7:0]  modrm_eff;
   uop_t        push_uop;
   uop_t        out_uop;

   // no ModRM byte reads as a register form, so no memory access
   assign modrm_eff = modrm_present ? modrm : 8'hc0;

   decode_stage2 i_decode_stage2 (
      .ir (ir), .opcode (opcode), .operand_override (operand_override),
      .modrm (modrm_eff), .sib (sib), .sib_present (sib_present),
      .disp_present (disp_present), .disp_size (disp_size), .disp_sel (disp_sel),
      .imm_present (imm_present), .imm_size (imm_size), .imm_sel (imm_sel),
      .data_size (d_data_size), .sr1_needed (d_sr1_needed),
      .seg1_needed (d_seg1_needed), .mm1_needed (d_mm1_needed),
      .mem_rd (d_mem_rd), .mem_wr (d_mem_wr), .aluk (d_aluk),
      .ld_gpr1 (d_ld_gpr1), .ld_mm (d_ld_mm), .sr1 (d_sr1), .sr2 (d_sr2),
      .seg1 (d_seg1), .seg2 (d_seg2), .sib_index (d_sib_index),
      .sib_en (d_sib_en), .disp_en (d_disp_en), .cmpxchg (d_cmpxchg),
      .illegal (d_illegal), .sib_scale (d_sib_scale),
      .imm32 (d_imm32), .disp32 (d_disp32)
   );

   // pack for the FIFO
   assign push_uop = '{data_size: d_data_size, sr1_needed: d_sr1_needed,
                       seg1_needed: d_seg1_needed, mm1_needed: d_mm1_needed,
                       mem_rd: d_mem_rd, mem_wr: d_mem_wr, aluk: d_aluk,
                       ld_gpr1: d_ld_gpr1, ld_mm: d_ld_mm, sr1: d_sr1, sr2: d_sr2,
                       seg1: d_seg1, seg2: d_seg2, sib_index: d_sib_index,
                       sib_en: d_sib_en, disp_en: d_disp_en, cmpxchg: d_cmpxchg,
                       illegal: d_illegal, sib_scale: d_sib_scale,
                       imm32: d_imm32, disp32: d_disp32};

   uop_credit_queue #(
      .DEPTH      (DEPTH),
      .AG_CREDITS (AG_CREDITS)
   ) i_uop_credit_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (in_valid),
      .push_uop   (push_uop),
      .out_credit (out_credit),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_uop    (out_uop)
   );

   // unpack toward address generation
   assign data_size   = out_uop.data_size;
   assign sr1_needed  = out_uop.sr1_needed;
   assign seg1_needed = out_uop.seg1_needed;
   assign mm1_needed  = out_uop.mm1_needed;
   assign mem_rd      = out_uop.mem_rd;
   assign mem_wr      = out_uop.mem_wr;
   assign aluk        = out_uop.aluk;
   assign ld_gpr1     = out_uop.ld_gpr1;
   assign ld_mm       = out_uop.ld_mm;
   assign sr1         = out_uop.sr1;
   assign sr2         = out_uop.sr2;
   assign seg1        = out_uop.seg1;
   assign seg2        = out_uop.seg2;
   assign sib_index   = out_uop.sib_index;
   assign sib_en      = out_uop.sib_en;
   assign disp_en     = out_uop.disp_en;
   assign cmpxchg     = out_uop.cmpxchg;
   assign illegal     = out_uop.illegal;
   assign sib_scale   = out_uop.sib_scale;
   assign imm32       = out_uop.imm32;
   assign disp32      = out_uop.disp32;

endmodule

// File: rtl/uop_credit_queue.sv
`timescale 1ns/1ps

module uop_credit_queue
   import decode_pkg::*;
#(
   parameter int DEPTH      = 4,
   parameter int AG_CREDITS = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  uop_t push_uop,
   input  logic out_credit,
   output logic in_credit,
   output logic out_valid,
   output uop_t out_uop
);

   localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int cnt_w = $clog2(DEPTH + 1);
   localparam int crd_w = $clog2(AG_CREDITS + 1);

   uop_t             mem [DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic [crd_w-1:0] credits;
   logic             pop;

   // leave only while address generation has room
   assign pop       = (count != '0) && (credits != '0);
   assign out_valid = pop;
   assign out_uop   = mem[rd_ptr];

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_uop;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         credits   <= crd_w'(AG_CREDITS);
         in_credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // one credit spent per beat, one back per out_credit
         case ({out_credit, pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
         // slot freed, hand it back to decode stage 1
         in_credit <= pop;
      end
   end

   // upstream credits keep the sender from overrunning the FIFO
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (count != cnt_w'(DEPTH)))
      else $error("uop_credit_queue: push while full");

   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= crd_w'(AG_CREDITS))
      else $error("uop_credit_queue: credit counter above AG_CREDITS");

   // downstream cannot return a credit it was never given
   a_no_extra_credit: assert property (@(posedge clk) disable iff (!rst_n)
      out_credit |-> (credits != crd_w'(AG_CREDITS)))
      else $error("uop_credit_queue: out_credit with counter already full");

endmodule

// File: rtl/decode_stage2.sv
`timescale 1ns/1ps

module decode_stage2
   import decode_pkg::*;
(
   input  logic [ir_w-1:0] ir,
   input  logic [15:0]     opcode,
   input  logic            operand_override,
   input  logic [7:0]      modrm,
   input  logic [7:0]      sib,
   input  logic            sib_present,
   input  logic            disp_present,
   input  logic            disp_size,
   input  logic [2:0]      disp_sel,
   input  logic            imm_present,
   input  logic [1:0]      imm_size,
   input  logic [3:0]      imm_sel,
   output logic [1:0]      data_size,
   output logic            sr1_needed,
   output logic            seg1_needed,
   output logic            mm1_needed,
   output logic            mem_rd,
   output logic            mem_wr,
   output logic [2:0]      aluk,
   output logic            ld_gpr1,
   output logic            ld_mm,
   output logic [2:0]      sr1,
   output logic [2:0]      sr2,
   output logic [2:0]      seg1,
   output logic [2:0]      seg2,
   output logic [2:0]      sib_index,
   output logic            sib_en,
   output logic            disp_en,
   output logic            cmpxchg,
   output logic            illegal,
   output logic [1:0]      sib_scale,
   output logic [31:0]     imm32,
   output logic [31:0]     disp32
);

   logic [ctrl_w-1:0] ctrl;
   logic [31:0]       disp_raw;
   logic [31:0]       imm_raw;
   logic              mod_is_reg;
   logic              op_is_0f7f;
   logic              op_is_mmx;
   logic [2:0]        modrm_reg;
   logic [2:0]        modrm_rm;

   field_extract i_field_extract (
      .ir        (ir),
      .disp_sel  (disp_sel),
      .disp_size (disp_size),
      .imm_sel   (imm_sel),
      .imm_size  (imm_size),
      .disp32    (disp_raw),
      .imm32     (imm_raw)
   );

   ucode_rom i_ucode_rom (
      .opcode (opcode),
      .ctrl   (ctrl)
   );

   // ModRM fields
   assign mod_is_reg = (modrm[7:6] == 2'b11);
   assign modrm_reg  = modrm[5:3];
   assign modrm_rm   = modrm[2:0];

   assign op_is_0f7f = (opcode == op_movq_rm_mm);
   assign op_is_mmx  = op_is_0f7f || (opcode == op_movq_mm_rm);

   // memory access only for the memory forms of r/m
   assign mem_rd = ctrl[cs_mux_mem_rd_pos] ? !mod_is_reg : ctrl[cs_mem_rd_pos];
   assign mem_wr = ctrl[cs_mux_mem_wr_pos] ? !mod_is_reg : ctrl[cs_mem_wr_pos];
   assign seg1_needed = !mod_is_reg;
   // ADD r,rm writes its reg operand even from memory
   assign ld_gpr1 = ctrl[cs_mux_ld_gpr1_pos] ? (mod_is_reg || opcode == op_add_r_rm)
                                             : ctrl[cs_ld_gpr1_pos];

   // group-1 takes its operation from the reg field
   assign aluk = ctrl[cs_mux_aluk_pos] ? modrm_reg : ctrl[cs_aluk_lsb +: 3];
   // 66h prefix shrinks gpr operands to 16 bits, mmx stays 64
   assign data_size = (operand_override && !op_is_mmx) ? ds_word
                                                       : ctrl[cs_data_size_lsb +: 2];

   // base register, SIB base wins over rm
   assign sr1       = sib_present ? sib[2:0] : modrm_rm;
   assign sr2       = modrm_reg;
   assign sib_index = sib[5:3];
   assign sib_scale = sib[7:6];
   assign sib_en    = sib_present;
   assign disp_en   = disp_present;

   assign seg1 = seg_id_ds;
   assign seg2 = seg_id_ss;

   // MOVQ mm/m64,mm register form writes the rm mmx register
   assign ld_mm      = ctrl[cs_ld_mm_pos] || (mod_is_reg && op_is_0f7f);
   assign mm1_needed = ctrl[cs_mm1_needed_pos] && mod_is_reg && !op_is_0f7f;
   // mmx memory forms need a gpr base for the address
   assign sr1_needed = ctrl[cs_sr1_needed_pos] || (ctrl[cs_mm1_needed_pos] && !mod_is_reg);

   // both byte and dword CMPXCHG
   assign cmpxchg = ({opcode[15:1], 1'b0} == 16'h0FB0);
   assign illegal = ctrl[cs_illegal_pos];

   assign imm32  = imm_present ? imm_raw : '0;
   assign disp32 = disp_present ? disp_raw : '0;

endmodule

// File: rtl/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom
   import decode_pkg::*;
(
   input  logic [15:0]       opcode,
   output logic [ctrl_w-1:0] ctrl
);

   always_comb begin
      // common word for the gpr r/m forms
      logic [ctrl_w-1:0] gpr_rm;

      gpr_rm = '0;
      // memory access chosen by ModRM.mod in stage 2
      gpr_rm[cs_mux_mem_rd_pos]  = 1'b1;
      gpr_rm[cs_mux_mem_wr_pos]  = 1'b1;
      gpr_rm[cs_mux_ld_gpr1_pos] = 1'b1;
      gpr_rm[cs_ld_gpr1_pos]     = 1'b1;
      gpr_rm[cs_sr1_needed_pos]  = 1'b1;
      gpr_rm[cs_aluk_lsb +: 3]   = aluk_add;
      gpr_rm[cs_data_size_lsb +: 2] = ds_dword;
      // sources come from ModRM rm/base and reg
      gpr_rm[cs_mux_sr1_pos]     = 1'b1;
      gpr_rm[cs_mux_sr2_pos]     = 1'b1;

      ctrl = '0;
      case (opcode)
         op_add_rm_r: begin
            ctrl = gpr_rm;
         end
         op_add_r_rm: begin
            // destination is always the reg operand
            ctrl = gpr_rm;
            ctrl[cs_mux_mem_wr_pos] = 1'b0;
         end
         op_grp1_imm: begin
            // add/or/adc/.../cmp picked by ModRM.reg
            ctrl = gpr_rm;
            ctrl[cs_mux_aluk_pos] = 1'b1;
         end
         op_mov_rm_r: begin
            // store only, no read of the old r/m value
            ctrl = gpr_rm;
            ctrl[cs_aluk_lsb +: 3]   = aluk_pass;
            ctrl[cs_mux_mem_rd_pos]  = 1'b0;
         end
         op_movq_mm_rm: begin
            ctrl[cs_mm1_needed_pos]  = 1'b1;
            ctrl[cs_ld_mm_pos]       = 1'b1;
            ctrl[cs_mux_mem_rd_pos]  = 1'b1;
            ctrl[cs_data_size_lsb +: 2] = ds_qword;
         end
         op_movq_rm_mm: begin
            // ld_mm for the register form is added in stage 2
            ctrl[cs_mm1_needed_pos]  = 1'b1;
            ctrl[cs_mux_mem_wr_pos]  = 1'b1;
            ctrl[cs_data_size_lsb +: 2] = ds_qword;
         end
         op_cmpxchg: begin
            ctrl = gpr_rm;
            ctrl[cs_aluk_lsb +: 3]   = aluk_cmp;
         end
         default: begin
            // not in the table
            ctrl[cs_illegal_pos]     = 1'b1;
         end
      endcase
   end

endmodule

// File: rtl/field_extract.sv
`timescale 1ns/1ps

module field_extract
   import decode_pkg::*;
(
   input  logic [ir_w-1:0] ir,
   input  logic [2:0]      disp_sel,
   input  logic            disp_size,
   input  logic [3:0]      imm_sel,
   input  logic [1:0]      imm_size,
   output logic [31:0]     disp32,
   output logic [31:0]     imm32
);

   // window shifted so the field's first byte lands in byte 0
   logic [ir_w-1:0] disp_win;
   logic [ir_w-1:0] imm_win;

   // byte k sits at bits 8k+7:8k, bytes past the window end read as zero
   assign disp_win = ir >> {disp_sel, 3'b000};
   assign imm_win  = ir >> {imm_sel, 3'b000};

   // displacement, little endian
   always_comb begin
      if (disp_size) begin
         disp32 = disp_win[31:0];
      end else begin
         // disp8 is signed
         disp32 = {{24{disp_win[7]}}, disp_win[7:0]};
      end
   end

   // immediate, imm8 and imm16 sign-extended
   always_comb begin
      case (imm_size)
         2'b00: begin
            imm32 = {{24{imm_win[7]}}, imm_win[7:0]};
         end
         2'b01: begin
            imm32 = {{16{imm_win[15]}}, imm_win[15:0]};
         end
         2'b10: begin
            imm32 = imm_win[31:0];
         end
         default: begin
            imm32 = '0;
         end
      endcase
   end

   // decode stage 1 only ever reports 8, 16 or 32-bit immediates
   always_comb begin
      assert #0 (imm_size !== 2'b11)
         else $error("field_extract: imm_size 11 is not a legal immediate size");
   end

endmodule

// File: rtl/decode_pkg.sv
package decode_pkg;

   // instruction window and control word widths
   localparam int ir_w   = 128;
   localparam int ctrl_w = 18;

   // control word bit positions
   localparam int cs_mem_rd_pos      = 0;
   localparam int cs_mux_mem_rd_pos  = 1;
   localparam int cs_mem_wr_pos      = 2;
   localparam int cs_mux_mem_wr_pos  = 3;
   // 3-bit alu operation field
   localparam int cs_aluk_lsb        = 4;
   localparam int cs_mux_aluk_pos    = 7;
   localparam int cs_ld_gpr1_pos     = 8;
   localparam int cs_mux_ld_gpr1_pos = 9;
   localparam int cs_sr1_needed_pos  = 10;
   localparam int cs_mm1_needed_pos  = 11;
   localparam int cs_ld_mm_pos       = 12;
   localparam int cs_mux_sr1_pos     = 13;
   localparam int cs_mux_sr2_pos     = 14;
   // 2-bit operand size field
   localparam int cs_data_size_lsb   = 15;
   localparam int cs_illegal_pos     = 17;

   // opcodes held in the control store, high byte 00 for one-byte opcodes
   localparam logic [15:0] op_add_rm_r   = 16'h0001;
   localparam logic [15:0] op_add_r_rm   = 16'h0003;
   localparam logic [15:0] op_grp1_imm   = 16'h0081;
   localparam logic [15:0] op_mov_rm_r   = 16'h0089;
   localparam logic [15:0] op_movq_mm_rm = 16'h0F6F;
   localparam logic [15:0] op_movq_rm_mm = 16'h0F7F;
   localparam logic [15:0] op_cmpxchg    = 16'h0FB1;

   // operand size encoding
   localparam logic [1:0] ds_byte  = 2'b00;
   localparam logic [1:0] ds_word  = 2'b01;
   localparam logic [1:0] ds_dword = 2'b10;
   localparam logic [1:0] ds_qword = 2'b11;

   // alu operations
   localparam logic [2:0] aluk_add  = 3'b000;
   localparam logic [2:0] aluk_cmp  = 3'b001;
   localparam logic [2:0] aluk_pass = 3'b111;

   // fixed segment ids, DS for the memory operand and SS for the stack
   localparam logic [2:0] seg_id_ds = 3'b011;
   localparam logic [2:0] seg_id_ss = 3'b010;

   // decoded micro-op as queued toward address generation
   typedef struct packed {
      logic [1:0]  data_size;
      logic        sr1_needed;
      logic        seg1_needed;
      logic        mm1_needed;
      logic        mem_rd;
      logic        mem_wr;
      logic [2:0]  aluk;
      logic        ld_gpr1;
      logic        ld_mm;
      logic [2:0]  sr1;
      logic [2:0]  sr2;
      logic [2:0]  seg1;
      logic [2:0]  seg2;
      logic [2:0]  sib_index;
      logic        sib_en;
      logic        disp_en;
      logic        cmpxchg;
      logic        illegal;
      logic [1:0]  sib_scale;
      logic [31:0] imm32;
      logic [31:0] disp32;
   } uop_t;

endpackage
